// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= femtoCoreTb
FILELIST  ?= femtoCore.f
OBJDIR    ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJDIR)

// ==== design/femtoCore.sv ====
// Top of the multi-cycle RV32I core, exposes one memory request and one response struct
`default_nettype none

module femtoCore (
   input  logic           clk,
   input  logic           reset,
   output rvPkg::memReq_t memReq,
   input  rvPkg::memRsp_t memRsp
);
   import rvPkg::*;

   decodedInstr_t dec;
   word_t         instr;
   word_t         rs1Data;
   word_t         rs2Data;
   word_t         aluOut;
   word_t         aluPlus;
   word_t         loadData;
   word_t         writeData;
   addr_t         addr;
   byteMask_t     storeMask;
   logic          regReadEn;
   logic          regWriteEn;
   logic          takeBranch;

   assign memReq.addr = {{(XLEN-ADDR_WIDTH){1'b0}}, addr};  // Zero pad to 32 bits

   // ****************************************
   // Core units
   // ****************************************
   rvControl u_control (
      .clk        (clk),
      .reset      (reset),
      .dec        (dec),
      .aluOut     (aluOut),
      .aluPlus    (aluPlus),
      .loadData   (loadData),
      .takeBranch (takeBranch),
      .storeMask  (storeMask),
      .memRsp     (memRsp),
      .instr      (instr),
      .regReadEn  (regReadEn),
      .regWriteEn (regWriteEn),
      .writeData  (writeData),
      .addr       (addr),
      .wmask      (memReq.wmask),
      .rstrb      (memReq.rstrb)
   );

   rvDecoder u_decoder (
      .instr (instr),
      .dec   (dec)
   );

   // Read indices come straight off the fetched word
   rvRegFile u_regFile (
      .clk       (clk),
      .readEn    (regReadEn),
      .rs1Idx    (memRsp.rdata[19:15]),
      .rs2Idx    (memRsp.rdata[24:20]),
      .rs1Data   (rs1Data),
      .rs2Data   (rs2Data),
      .writeEn   (regWriteEn),
      .rdIdx     (dec.rd),
      .writeData (writeData)
   );

   rvAlu u_alu (
      .dec        (dec),
      .rs1Data    (rs1Data),
      .rs2Data    (rs2Data),
      .aluOut     (aluOut),
      .aluPlus    (aluPlus),
      .takeBranch (takeBranch)
   );

   rvLoadStore u_loadStore (
      .addrLow   (addr[1:0]),
      .funct3    (dec.funct3),
      .rs2Data   (rs2Data),
      .rdata     (memRsp.rdata),
      .loadData  (loadData),
      .wdata     (memReq.wdata),
      .storeMask (storeMask)
   );

endmodule

`default_nettype wire

// ==== design/rvAlu.sv ====
// Combinational ALU with the address adder, one shared subtractor and the branch predicate
`default_nettype none

module rvAlu (
   input  rvPkg::decodedInstr_t dec,
   input  rvPkg::word_t         rs1Data,
   input  rvPkg::word_t         rs2Data,
   output rvPkg::word_t         aluOut,
   output rvPkg::word_t         aluPlus,
   output logic                 takeBranch
);
   import rvPkg::*;

   word_t         aluIn2;
   logic [XLEN:0] aluMinus;      // Carry out is the unsigned borrow
   logic          lt;
   logic          ltu;
   logic          eq;
   logic [7:0]    funct3Equals;  // One-hot funct3

   // rs2 for register ops and branches, immediate otherwise
   assign aluIn2 = (dec.isAluReg | dec.isBranch) ? rs2Data : dec.imm;

   assign aluPlus = rs1Data + aluIn2;  // Also load/store and JALR address

   // ****************************************
   // Single subtract for SUB and compares
   // ****************************************
   assign aluMinus = {1'b1, ~aluIn2} + {1'b0, rs1Data} + {{XLEN{1'b0}}, 1'b1};
   assign ltu = aluMinus[XLEN];
   assign lt  = (rs1Data[XLEN-1] ^ aluIn2[XLEN-1]) ? rs1Data[XLEN-1] : aluMinus[XLEN];
   assign eq  = (aluMinus[XLEN-1:0] == '0);

   assign funct3Equals = 8'b0000_0001 << dec.funct3;

   // Shift codes 1 and 5 fall through as zero
   assign aluOut =
      (funct3Equals[0] ? (dec.isSub ? aluMinus[XLEN-1:0] : aluPlus) : '0) |  // ADD/SUB
      (funct3Equals[2] ? {{(XLEN-1){1'b0}}, lt}                     : '0) |  // SLT
      (funct3Equals[3] ? {{(XLEN-1){1'b0}}, ltu}                    : '0) |  // SLTU
      (funct3Equals[4] ? (rs1Data ^ aluIn2)                         : '0) |  // XOR
      (funct3Equals[6] ? (rs1Data | aluIn2)                         : '0) |  // OR
      (funct3Equals[7] ? (rs1Data & aluIn2)                         : '0);   // AND

   // Branch predicate, qualified by isBranch in control
   assign takeBranch = (funct3Equals[0] &  eq)  |  // BEQ
                       (funct3Equals[1] & ~eq)  |  // BNE
                       (funct3Equals[4] &  lt)  |  // BLT
                       (funct3Equals[5] & ~lt)  |  // BGE
                       (funct3Equals[6] &  ltu) |  // BLTU
                       (funct3Equals[7] & ~ltu);   // BGEU

endmodule

`default_nettype wire

// ==== design/rvControl.sv ====
// Core sequencer with the one-hot FSM, program counter, address register and write-back select
`default_nettype none

module rvControl (
   input  logic                 clk,
   input  logic                 reset,
   input  rvPkg::decodedInstr_t dec,
   input  rvPkg::word_t         aluOut,
   input  rvPkg::word_t         aluPlus,
   input  rvPkg::word_t         loadData,
   input  logic                 takeBranch,
   input  rvPkg::byteMask_t     storeMask,
   input  rvPkg::memRsp_t       memRsp,
   output rvPkg::word_t         instr,
   output logic                 regReadEn,
   output logic                 regWriteEn,
   output rvPkg::word_t         writeData,
   output rvPkg::addr_t         addr,
   output rvPkg::byteMask_t     wmask,
   output logic                 rstrb
);
   import rvPkg::*;

   coreState_t state;
   addr_t      pc;
   addr_t      pcPlus4;
   addr_t      pcPlusImm;    // Branch, JAL and AUIPC target
   logic       memIdle;
   logic       isAlu;
   logic       jumpToImm;

   assign memIdle   = ~memRsp.rbusy & ~memRsp.wbusy;
   assign isAlu     = dec.isAluImm | dec.isAluReg;
   assign jumpToImm = dec.isJal | (dec.isBranch & takeBranch);

   assign pcPlus4   = pc + addr_t'(4);
   assign pcPlusImm = pc + dec.imm[ADDR_WIDTH-1:0];

   // ****************************************
   // Outputs decoded from the state
   // ****************************************
   assign rstrb     = (state == FETCH_INSTR) | (state == LOAD);
   assign wmask     = {4{state == STORE}} & storeMask;   // Single STORE cycle
   assign regReadEn = (state == WAIT_INSTR) & ~memRsp.rbusy;

   // Loads write back on leaving WAIT_MEM, the rest in EXECUTE
   assign regWriteEn =
      ((state == EXECUTE) & ~(dec.isBranch | dec.isStore | dec.isLoad)) |
      ((state == WAIT_MEM) & dec.isLoad & memIdle);

   // Unmatched opcodes select nothing and write zero
   assign writeData =
      (dec.isLui                ? dec.imm                                  : '0) |
      (isAlu                    ? aluOut                                   : '0) |
      (dec.isAuipc              ? {{(XLEN-ADDR_WIDTH){1'b0}}, pcPlusImm}   : '0) |
      ((dec.isJal | dec.isJalr) ? {{(XLEN-ADDR_WIDTH){1'b0}}, pcPlus4}     : '0) |
      (dec.isLoad               ? loadData                                 : '0);

   // ****************************************
   // State machine and PC
   // ****************************************
   always_ff @(posedge clk) begin
      if (!reset) begin
         state <= WAIT_MEM;        // Waits for idle memory, then fetches
         pc    <= RESET_ADDR;
      end else begin
         case (state)
            FETCH_INSTR: state <= WAIT_INSTR;   // Address and strobe out this cycle

            WAIT_INSTR: begin
               if (!memRsp.rbusy) begin
                  instr <= memRsp.rdata;        // Register reads start in parallel
                  state <= EXECUTE;
               end
            end

            EXECUTE: begin
               pc <= dec.isJalr ? aluPlus[ADDR_WIDTH-1:0] :
                     jumpToImm  ? pcPlusImm :
                                  pcPlus4;
               // Data address for memory ops, otherwise the next fetch
               addr <= (dec.isJalr | dec.isLoad | dec.isStore) ? aluPlus[ADDR_WIDTH-1:0] :
                       jumpToImm                               ? pcPlusImm :
                                                                 pcPlus4;
               state <= dec.isLoad  ? LOAD :
                        dec.isStore ? STORE :
                                      FETCH_INSTR;
            end

            LOAD,
            STORE: state <= WAIT_MEM;

            WAIT_MEM: begin
               if (memIdle) begin
                  addr  <= pc;             // Back to fetching
                  state <= FETCH_INSTR;
               end
            end

            default: state <= WAIT_MEM;   // Recover from an illegal encoding
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== design/rvDecoder.sv ====
// Combinational decoder, turns the latched instruction word into flags and the selected immediate
`default_nettype none

module rvDecoder (
   input  rvPkg::word_t         instr,
   output rvPkg::decodedInstr_t dec
);
   import rvPkg::*;

   logic [4:0] opcode;   // Bits 1:0 are always 11 in RV32I
   word_t      uImm;
   word_t      iImm;
   word_t      sImm;
   word_t      bImm;
   word_t      jImm;

   assign opcode = instr[6:2];

   // ****************************************
   // The five immediate formats
   // ****************************************
   assign uImm = {instr[31:12], 12'b0};
   assign iImm = {{21{instr[31]}}, instr[30:20]};
   assign sImm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
   assign bImm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
   assign jImm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

   // Opcode match, shifts share ALU opcodes, SYSTEM matches nothing
   assign dec.isLoad   = (opcode == 5'b00000);  // rd <- mem[rs1+Iimm]
   assign dec.isAluImm = (opcode == 5'b00100);  // rd <- rs1 OP Iimm
   assign dec.isAuipc  = (opcode == 5'b00101);  // rd <- PC + Uimm
   assign dec.isStore  = (opcode == 5'b01000);  // mem[rs1+Simm] <- rs2
   assign dec.isAluReg = (opcode == 5'b01100);  // rd <- rs1 OP rs2
   assign dec.isLui    = (opcode == 5'b01101);  // rd <- Uimm
   assign dec.isBranch = (opcode == 5'b11000);  // PC <- PC+Bimm if predicate
   assign dec.isJalr   = (opcode == 5'b11001);  // rd <- PC+4, PC <- rs1+Iimm
   assign dec.isJal    = (opcode == 5'b11011);  // rd <- PC+4, PC <- PC+Jimm

   assign dec.rd     = instr[11:7];
   assign dec.funct3 = instr[14:12];
   assign dec.isSub  = instr[30] & instr[5];    // Bit 5 low for ADDI, whose imm owns bit 30

   // Immediate the operation needs
   assign dec.imm = (dec.isLui | dec.isAuipc) ? uImm :
                    dec.isJal                 ? jImm :
                    dec.isBranch              ? bImm :
                    dec.isStore               ? sImm :
                                                iImm;  // ALU imm, load, JALR

endmodule

`default_nettype wire

// ==== design/rvLoadStore.sv ====
// Byte lane steering for loads and stores on the word-wide memory port
`default_nettype none

module rvLoadStore (
   input  logic [1:0]       addrLow,
   input  rvPkg::funct3_t   funct3,
   input  rvPkg::word_t     rs2Data,
   input  rvPkg::word_t     rdata,
   output rvPkg::word_t     loadData,
   output rvPkg::word_t     wdata,
   output rvPkg::byteMask_t storeMask
);

   logic        byteAccess;
   logic        halfAccess;
   logic        loadSign;
   logic [15:0] loadHalf;
   logic [7:0]  loadByte;

   // funct3[1:0] gives the width: 00 byte, 01 half, 10 word
   assign byteAccess = (funct3[1:0] == 2'b00);
   assign halfAccess = (funct3[1:0] == 2'b01);

   // ****************************************
   // Load path
   // ****************************************
   assign loadHalf = addrLow[1] ? rdata[31:16] : rdata[15:0];       // Halfword first
   assign loadByte = addrLow[0] ? loadHalf[15:8] : loadHalf[7:0];   // Then byte inside it

   // funct3[2] set means LBU/LHU
   assign loadSign = ~funct3[2] & (byteAccess ? loadByte[7] : loadHalf[15]);

   assign loadData = byteAccess ? {{24{loadSign}}, loadByte} :
                     halfAccess ? {{16{loadSign}}, loadHalf} :
                                  rdata;

   // ****************************************
   // Store path
   // ****************************************
   // Low byte or halfword copied to every lane it may land in
   assign wdata[7:0]   = rs2Data[7:0];
   assign wdata[15:8]  = addrLow[0] ? rs2Data[7:0] : rs2Data[15:8];
   assign wdata[23:16] = addrLow[1] ? rs2Data[7:0] : rs2Data[23:16];
   assign wdata[31:24] = addrLow[0] ? rs2Data[7:0] :
                         addrLow[1] ? rs2Data[15:8] :
                                      rs2Data[31:24];

   // Lane mask, gated with the STORE state in control
   assign storeMask = byteAccess ? (4'b0001 << addrLow) :
                      halfAccess ? (addrLow[1] ? 4'b1100 : 4'b0011) :
                                   4'b1111;

endmodule

`default_nettype wire

// ==== design/rvPkg.sv ====
// Shared constants, vector types, structs and state encoding, imported by every unit of the core
`default_nettype none

package rvPkg;

   // ****************************************
   // Widths and reset values
   // ****************************************
   localparam int unsigned XLEN       = 32;   // Data word width
   localparam int unsigned ADDR_WIDTH = 24;   // Internal address register width

   typedef logic [XLEN-1:0]       word_t;
   typedef logic [ADDR_WIDTH-1:0] addr_t;     // Zero-padded to 32 bits at the port
   typedef logic [4:0]            regIdx_t;
   typedef logic [2:0]            funct3_t;
   typedef logic [3:0]            byteMask_t; // One bit per byte lane

   localparam addr_t RESET_ADDR = '0;         // First fetch address

   // Decoded instruction, one flag per kept opcode
   typedef struct packed {
      logic    isLoad;
      logic    isAluImm;
      logic    isAuipc;
      logic    isStore;
      logic    isAluReg;
      logic    isLui;
      logic    isBranch;
      logic    isJalr;
      logic    isJal;
      regIdx_t rd;
      funct3_t funct3;
      logic    isSub;    // SUB only, never ADDI
      word_t   imm;      // Immediate already picked for the opcode
   } decodedInstr_t;

   // Memory port
   typedef struct packed {
      word_t     addr;
      word_t     wdata;
      byteMask_t wmask;  // Non-zero only in the STORE cycle
      logic      rstrb;  // Pulse in FETCH_INSTR and LOAD
   } memReq_t;

   typedef struct packed {
      word_t rdata;
      logic  rbusy;      // Level, holds WAIT_INSTR / WAIT_MEM
      logic  wbusy;      // Level, holds WAIT_MEM
   } memRsp_t;

   // One-hot core states
   typedef enum logic [5:0] {
      FETCH_INSTR = 6'b000001,
      WAIT_INSTR  = 6'b000010,
      EXECUTE     = 6'b000100,
      LOAD        = 6'b001000,
      WAIT_MEM    = 6'b010000,
      STORE       = 6'b100000
   } coreState_t;

endpackage

`default_nettype wire

// ==== design/rvRegFile.sv ====
// Register file of 32 words, read at instruction fetch and written back after execute or load
`default_nettype none

module rvRegFile (
   input  logic           clk,
   input  logic           readEn,
   input  rvPkg::regIdx_t rs1Idx,
   input  rvPkg::regIdx_t rs2Idx,
   output rvPkg::word_t   rs1Data,
   output rvPkg::word_t   rs2Data,
   input  logic           writeEn,
   input  rvPkg::regIdx_t rdIdx,
   input  rvPkg::word_t   writeData
);
   import rvPkg::*;

   word_t regs [32];   // Entry 0 is never written

   // Registered reads, x0 forced to zero
   always_ff @(posedge clk) begin
      if (readEn) begin
         rs1Data <= (rs1Idx == '0) ? '0 : regs[rs1Idx];
         rs2Data <= (rs2Idx == '0) ? '0 : regs[rs2Idx];
      end
   end

   // Write port
   always_ff @(posedge clk) begin
      if (writeEn && (rdIdx != '0)) begin
         regs[rdIdx] <= writeData;
      end
   end

endmodule

`default_nettype wire

// ==== femtoCore.f ====
design/rvPkg.sv
design/rvDecoder.sv
design/rvRegFile.sv
design/rvAlu.sv
design/rvLoadStore.sv
design/rvControl.sv
design/femtoCore.sv
verification/tbMemory.sv
verification/femtoCoreTb.sv

// ==== verification/femtoCoreTb.sv ====
// Directed testbench for the RV32I core, builds small programs, runs them and checks every store
`default_nettype none

module femtoCoreTb;
   timeunit 1ns;
   timeprecision 100ps;
   import rvPkg::*;

   localparam word_t RESULT_BASE  = 32'h200;   // Results stored upward from here
   localparam word_t DATA_BASE    = 32'h380;   // Scratch word for byte and halfword tests
   localparam word_t DONE_ADDR    = 32'h3FC;   // Last store of every program
   localparam int    RESET_CYCLES = 10;
   localparam logic [6:0] OP_LOAD   = 7'b0000011;
   localparam logic [6:0] OP_IMM    = 7'b0010011;
   localparam logic [6:0] OP_AUIPC  = 7'b0010111;
   localparam logic [6:0] OP_STORE  = 7'b0100011;
   localparam logic [6:0] OP_REG    = 7'b0110011;
   localparam logic [6:0] OP_LUI    = 7'b0110111;
   localparam logic [6:0] OP_BRANCH = 7'b1100011;
   localparam logic [6:0] OP_JALR   = 7'b1100111;
   localparam logic [6:0] OP_JAL    = 7'b1101111;

   logic      clk = 1'b0;
   logic      reset;
   logic      stallEn;
   logic      loadEn;
   logic [7:0] loadAddr;
   word_t     loadData;
   memReq_t   memReq;
   memRsp_t   memRsp;
   word_t     prog [$];                 // Program being built
   word_t     expAddr [$];
   word_t     expWord [$];
   byteMask_t expMask [$];
   word_t     gotAddr [$];              // Stores seen on the port
   word_t     gotWord [$];
   byteMask_t gotMask [$];
   word_t     resultAddr;
   logic      doneSeen;
   logic      strobeLast;               // Read strobe of the previous cycle
   int        errorCount = 0;
   int        checkCount = 0;
   int        testCount  = 0;
   longint    cycles     = 0;
   longint    cycleLimit = 20;          // Grows with every program run

   always #10 clk = ~clk;

   femtoCore u_femtoCore (.clk(clk), .reset(reset), .memReq(memReq), .memRsp(memRsp));

   tbMemory u_memory (
      .clk(clk), .reset(reset), .memReq(memReq), .memRsp(memRsp), .stallEn(stallEn),
      .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData)
   );

   // Store monitor that ends a program at the done store
   always @(posedge clk) begin
      if (!reset) begin
         doneSeen <= 1'b0;
         gotAddr.delete();
         gotWord.delete();
         gotMask.delete();
      end else if (memReq.wmask != '0) begin
         if (memReq.addr == DONE_ADDR) doneSeen <= 1'b1;
         else begin
            gotAddr.push_back(memReq.addr);
            gotWord.push_back(memReq.wdata);
            gotMask.push_back(memReq.wmask);
         end
      end
   end

   // Read strobe is a single-cycle pulse and never overlaps a store
   always @(posedge clk) begin
      if (!reset) begin
         strobeLast <= 1'b0;
      end else begin
         if (memReq.rstrb && strobeLast) begin
            $display("** Error @ %0t: read strobe high for two cycles in a row", $time);
            errorCount++;
         end
         if (memReq.rstrb && (memReq.wmask != '0)) begin
            $display("** Error @ %0t: read strobe and write mask active together", $time);
            errorCount++;
         end
         strobeLast <= memReq.rstrb;
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > cycleLimit) begin
         $display("Timeout after %0d cycles, the core never reached its done store", cycles);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   // ****************************************
   // Instruction encoders
   // ****************************************
   function automatic word_t encR(logic [6:0] f7, regIdx_t rs2, regIdx_t rs1, funct3_t f3,
                                  regIdx_t rd);
      return {f7, rs2, rs1, f3, rd, OP_REG};
   endfunction

   function automatic word_t encI(logic [11:0] imm, regIdx_t rs1, funct3_t f3, regIdx_t rd,
                                  logic [6:0] op);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic word_t encS(logic [11:0] imm, regIdx_t rs2, regIdx_t rs1, funct3_t f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
   endfunction

   function automatic word_t encB(logic [12:0] off, regIdx_t rs2, regIdx_t rs1, funct3_t f3);
      return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
   endfunction

   function automatic word_t encU(logic [19:0] imm, regIdx_t rd, logic [6:0] op);
      return {imm, rd, op};
   endfunction

   function automatic word_t encJ(logic [20:0] off, regIdx_t rd);
      return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
   endfunction

   // RV32I reference results
   function automatic word_t aluRef(funct3_t f3, logic sub, word_t a, word_t b);
      case (f3)
         3'd0:    return sub ? a - b : a + b;
         3'd2:    return word_t'($signed(a) < $signed(b));
         3'd3:    return word_t'(a < b);
         3'd4:    return a ^ b;
         3'd6:    return a | b;
         3'd7:    return a & b;
         default: return '0;
      endcase
   endfunction

   function automatic logic branchRef(funct3_t f3, word_t a, word_t b);
      case (f3)
         3'd0:    return a == b;
         3'd1:    return a != b;
         3'd4:    return $signed(a) < $signed(b);
         3'd5:    return $signed(a) >= $signed(b);
         3'd6:    return a < b;
         default: return a >= b;
      endcase
   endfunction

   function automatic word_t laneBits(byteMask_t m);
      return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
   endfunction

   function automatic word_t pcNow();
      return word_t'(prog.size() * 4);
   endfunction

   // ****************************************
   // Program building
   // ****************************************
   task automatic startProgram();
      prog.delete();
      expAddr.delete();
      expWord.delete();
      expMask.delete();
      resultAddr = RESULT_BASE;
   endtask

   task automatic loadConst(regIdx_t rd, word_t v);
      word_t upper;
      upper = (v + 32'h800) >> 12;   // Rounds for the sign of the low part
      prog.push_back(encU(upper[19:0], rd, OP_LUI));
      prog.push_back(encI(v[11:0], rd, 3'd0, rd, OP_IMM));
   endtask

   task automatic storeExpect(funct3_t f3, regIdx_t rs2, word_t a, word_t exp, byteMask_t m);
      prog.push_back(encS(a[11:0], rs2, 5'd0, f3));
      expAddr.push_back(a);
      expWord.push_back(exp);
      expMask.push_back(m);
   endtask

   task automatic storeReg(regIdx_t r, word_t exp);
      storeExpect(3'b010, r, resultAddr, exp, 4'hF);
      resultAddr += 4;
   endtask

   task automatic checkWord(string what, word_t got, word_t exp);
      checkCount++;
      if (got !== exp) begin
         $display("** Error @ %0t: %s is %h, expected %h", $time, what, got, exp);
         errorCount++;
      end
   endtask

   task automatic checkMask(string what, byteMask_t got, byteMask_t exp);
      checkCount++;
      if (got !== exp) begin
         $display("** Error @ %0t: %s is %b, expected %b", $time, what, got, exp);
         errorCount++;
      end
   endtask

   // Loads and resets the core, runs it to the done store and compares every store
   task automatic runProgram(string name, logic stalls);
      int errorsBefore;
      int n;
      errorsBefore = errorCount;
      prog.push_back(encS(DONE_ADDR[11:0], 5'd0, 5'd0, 3'b010));
      prog.push_back(encJ(21'd0, 5'd0));   // Spin until the next reset
      cycleLimit += prog.size() * 5 * 4 + prog.size() + RESET_CYCLES + 4;
      @(posedge clk);
      reset   <= 1'b0;
      stallEn <= stalls;
      foreach (prog[i]) begin
         @(posedge clk);
         loadEn   <= 1'b1;
         loadAddr <= 8'(i);
         loadData <= prog[i];
      end
      @(posedge clk);
      loadEn <= 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b1;
      @(posedge clk);
      while (!doneSeen) @(posedge clk);
      if (gotWord.size() != expWord.size()) begin
         $display("%s: %0d stores seen but %0d expected", name, gotWord.size(), expWord.size());
         errorCount++;
      end
      n = (gotWord.size() < expWord.size()) ? gotWord.size() : expWord.size();
      for (int i = 0; i < n; i++) begin
         checkWord({name, " address"}, gotAddr[i], expAddr[i]);
         checkWord({name, " data"}, gotWord[i] & laneBits(expMask[i]),
                   expWord[i] & laneBits(expMask[i]));     // Only the written lanes
         checkMask({name, " mask"}, gotMask[i], expMask[i]);
      end
      testCount++;
      $display("%s: %0d stores, %0d mismatches", name, n, errorCount - errorsBefore);
   endtask

   // ****************************************
   // Directed tests
   // ****************************************
   task automatic aluTest(string name, logic stalls);
      funct3_t     regF3 [7] = '{3'd0, 3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};
      logic        regSub [7] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
      funct3_t     immF3 [6] = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};
      word_t       ops [2] = '{32'hFFFF_FFF9, 32'd12345};   // -7 and 12345
      logic [11:0] imm = 12'hF9C;                            // -100
      word_t       a;
      word_t       b;
      startProgram();
      for (int p = 0; p < 2; p++) begin
         a = ops[p];
         b = ops[1-p];
         loadConst(5'd1, a);
         loadConst(5'd2, b);
         for (int k = 0; k < 7; k++) begin
            prog.push_back(encR(regSub[k] ? 7'h20 : 7'h00, 5'd2, 5'd1, regF3[k], 5'd3));
            storeReg(5'd3, aluRef(regF3[k], regSub[k], a, b));
         end
         for (int k = 0; k < 6; k++) begin
            prog.push_back(encI(imm, 5'd1, immF3[k], 5'd3, OP_IMM));
            storeReg(5'd3, aluRef(immF3[k], 1'b0, a, {{20{imm[11]}}, imm}));
         end
      end
      runProgram(name, stalls);
   endtask

   task automatic upperTest();
      word_t p;
      startProgram();
      prog.push_back(encU(20'hABCDE, 5'd5, OP_LUI));
      storeReg(5'd5, 32'hABCD_E000);
      p = pcNow();
      prog.push_back(encU(20'h00010, 5'd6, OP_AUIPC));
      storeReg(5'd6, p + 32'h0001_0000);
      p = pcNow();
      prog.push_back(encU(20'h0, 5'd6, OP_AUIPC));   // Own address
      storeReg(5'd6, p);
      runProgram("lui_auipc", 1'b0);
   endtask

   task automatic branchTest();
      funct3_t f3s [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
      regIdx_t lhs [3] = '{5'd1, 5'd1, 5'd2};
      regIdx_t rhs [3] = '{5'd2, 5'd1, 5'd1};
      word_t   val [3] = '{32'h0, 32'hFFFF_FFFD, 32'd5};   // x1 = -3, x2 = 5
      startProgram();
      loadConst(5'd1, val[1]);
      loadConst(5'd2, val[2]);
      for (int p = 0; p < 3; p++) begin
         foreach (f3s[k]) begin
            prog.push_back(encI(12'd1, 5'd0, 3'd0, 5'd7, OP_IMM));   // Taken marker
            prog.push_back(encB(13'd8, rhs[p], lhs[p], f3s[k]));
            prog.push_back(encI(12'd2, 5'd0, 3'd0, 5'd7, OP_IMM));   // Fall-through marker
            storeReg(5'd7, branchRef(f3s[k], val[lhs[p]], val[rhs[p]]) ? 32'd1 : 32'd2);
         end
      end
      runProgram("branches", 1'b0);
   endtask

   task automatic jumpTest();
      word_t p;
      startProgram();
      prog.push_back(encI(12'd5, 5'd0, 3'd0, 5'd9, OP_IMM));
      p = pcNow();
      prog.push_back(encJ(21'd8, 5'd8));
      prog.push_back(encI(12'd99, 5'd0, 3'd0, 5'd9, OP_IMM));   // Skipped
      storeReg(5'd8, p + 4);
      storeReg(5'd9, 32'd5);
      p = pcNow();
      prog.push_back(encI(12'(p + 12), 5'd0, 3'd0, 5'd10, OP_IMM));
      prog.push_back(encI(12'd0, 5'd10, 3'd0, 5'd11, OP_JALR));
      prog.push_back(encI(12'd77, 5'd0, 3'd0, 5'd9, OP_IMM));   // Skipped
      storeReg(5'd11, p + 8);
      storeReg(5'd9, 32'd5);
      prog.push_back(encI(12'd55, 5'd0, 3'd0, 5'd0, OP_IMM));   // x0 ignores both writes
      prog.push_back(encJ(21'd4, 5'd0));
      storeReg(5'd0, 32'd0);
      runProgram("jal_jalr", 1'b0);
   endtask

   task automatic memTest(string name, logic stalls);
      word_t v = 32'h80F1_7E92;
      word_t a;
      logic [7:0]  b;
      logic [15:0] h;
      startProgram();
      loadConst(5'd1, v);
      storeExpect(3'b010, 5'd1, DATA_BASE, v, 4'hF);
      storeExpect(3'b000, 5'd1, DATA_BASE + 5, {4{v[7:0]}}, 4'b0010);
      storeExpect(3'b001, 5'd1, DATA_BASE + 10, {2{v[15:0]}}, 4'b1100);
      for (int k = 0; k < 4; k++) begin
         a = DATA_BASE + k;
         b = v[8*k +: 8];
         prog.push_back(encI(a[11:0], 5'd0, 3'b000, 5'd4, OP_LOAD));   // LB
         storeReg(5'd4, {{24{b[7]}}, b});
         prog.push_back(encI(a[11:0], 5'd0, 3'b100, 5'd4, OP_LOAD));   // LBU
         storeReg(5'd4, {24'h0, b});
      end
      for (int k = 0; k < 4; k += 2) begin
         a = DATA_BASE + k;
         h = v[8*k +: 16];
         prog.push_back(encI(a[11:0], 5'd0, 3'b001, 5'd4, OP_LOAD));   // LH
         storeReg(5'd4, {{16{h[15]}}, h});
         prog.push_back(encI(a[11:0], 5'd0, 3'b101, 5'd4, OP_LOAD));   // LHU
         storeReg(5'd4, {16'h0, h});
      end
      prog.push_back(encI(DATA_BASE[11:0], 5'd0, 3'b010, 5'd4, OP_LOAD));
      storeReg(5'd4, v);
      a = DATA_BASE + 5;   // Read back the byte and halfword stores
      prog.push_back(encI(a[11:0], 5'd0, 3'b100, 5'd4, OP_LOAD));
      storeReg(5'd4, {24'h0, v[7:0]});
      a = DATA_BASE + 10;
      prog.push_back(encI(a[11:0], 5'd0, 3'b101, 5'd4, OP_LOAD));
      storeReg(5'd4, {16'h0, v[15:0]});
      runProgram(name, stalls);
   endtask

   initial begin
      reset    = 1'b0;
      stallEn  = 1'b0;
      loadEn   = 1'b0;
      loadAddr = '0;
      loadData = '0;
      void'($urandom(32'h8e70_02c5));
      aluTest("alu", 1'b0);
      upperTest();
      branchTest();
      jumpTest();
      memTest("load_store", 1'b0);
      aluTest("alu_stall", 1'b1);         // Same results under back-pressure
      memTest("load_store_stall", 1'b1);
      $display("Tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
      if (errorCount == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== verification/tbMemory.sv ====
// Word memory model for the core testbench, loaded through a side port, with optional random busy stalls
`default_nettype none

module tbMemory (
   input  logic           clk,
   input  logic           reset,
   input  rvPkg::memReq_t memReq,
   output rvPkg::memRsp_t memRsp,
   input  logic           stallEn,   // Random read and write busy when high
   input  logic           loadEn,    // Program load port, used while the core is in reset
   input  logic [7:0]     loadAddr,
   input  rvPkg::word_t   loadData
);
   timeunit 1ns;
   timeprecision 100ps;
   import rvPkg::*;

   word_t      mem [256];   // 1 KB
   logic [7:0] index;

   assign index = memReq.addr[9:2];

   // Loads from the testbench, byte lane writes from the core
   always @(posedge clk) begin
      if (loadEn) begin
         mem[loadAddr] <= loadData;
      end else begin
         for (int i = 0; i < 4; i++) begin
            if (memReq.wmask[i]) mem[index][8*i +: 8] <= memReq.wdata[8*i +: 8];
         end
      end
   end

   // ****************************************
   // Read data and busy levels
   // ****************************************
   always @(posedge clk) begin
      if (!reset) begin
         memRsp.rbusy <= 1'b0;
         memRsp.wbusy <= 1'b0;
      end else begin
         if (memReq.rstrb) begin
            memRsp.rdata <= mem[index];                            // Held until the next strobe
            memRsp.rbusy <= stallEn & $urandom_range(1, 0) == 1;
         end else if (memRsp.rbusy) begin
            memRsp.rbusy <= $urandom_range(1, 0) == 1;             // Drops after a random wait
         end
         if (memReq.wmask != '0) memRsp.wbusy <= stallEn & $urandom_range(1, 0) == 1;
         else if (memRsp.wbusy) memRsp.wbusy <= $urandom_range(1, 0) == 1;
      end
   end

endmodule

`default_nettype wire
